// ==== logic/udp_echo_macros.svh ====
// ======================================================================
// Widths, echo port and queue depths for the UDP echo core
// ======================================================================
`ifndef UDP_ECHO_MACROS_SVH
`define UDP_ECHO_MACROS_SVH

// Payload beat geometry
`define DATA_WIDTH 64
`define KEEP_WIDTH 8

`define ECHO_PORT 16'd1234
`define HDR_FIFO_DEPTH 4
`define PAYLOAD_FIFO_DEPTH 32
`endif

// ==== logic/udp_echo_pkg.sv ====
// ======================================================================
// Header and payload beat types shared by the UDP echo core
// ======================================================================
`include "udp_echo_macros.svh"

package udp_echo_pkg;

    // Header as delivered by the UDP receive stack
    typedef struct packed {
        logic [31:0] ip_source_ip;
        logic [15:0] source_port;
        logic [15:0] dest_port;
        logic [15:0] udp_length;
    } udp_hdr_t;

    // Header handed to the UDP transmit stack
    typedef struct packed {
        logic [31:0] ip_dest_ip;
        logic [15:0] source_port;
        logic [15:0] dest_port;
        logic [15:0] udp_length;
    } reply_hdr_t;

    typedef struct packed {
        logic [`DATA_WIDTH-1:0] tdata;
        logic [`KEEP_WIDTH-1:0] tkeep;
        logic                   tlast;
        logic                   tuser;
    } payload_beat_t;

endpackage

// ==== logic/stream_fifo.sv ====
// ======================================================================
// Valid/ready FIFO with a generic item type
// ======================================================================
`timescale 1ns/1ps

module stream_fifo #(
    parameter type item_t = logic [7:0],
    parameter int  depth  = 4
) (
    input  logic  clk,
    input  logic  rst,

    input  item_t in_item,
    input  logic  in_valid,
    output logic  in_ready,

    output item_t out_item,
    output logic  out_valid,
    input  logic  out_ready
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);
    localparam logic [ptr_w-1:0] last_slot  = ptr_w'(depth - 1);
    localparam logic [cnt_w-1:0] full_count = cnt_w'(depth);

    item_t            mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic             push;
    logic             pop;

    // Back-pressure only when every slot is taken
    assign in_ready  = (count != full_count);
    assign out_valid = (count != '0);
    assign out_item  = mem[rd_ptr];

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    // Storage
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_item;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == last_slot) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == last_slot) ? '0 : rd_ptr + 1'b1;
            end
            // Occupancy holds when push and pop coincide
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== logic/udp_port_filter.sv ====
// ======================================================================
// Destination port filter and reply header builder
// ======================================================================
`timescale 1ns/1ps
`include "udp_echo_macros.svh"

module udp_port_filter
    import udp_echo_pkg::*;
(
    input  logic          clk,
    input  logic          rst,

    input  udp_hdr_t      hdr_in,
    input  logic          hdr_in_valid,
    output logic          hdr_in_ready,

    input  payload_beat_t beat_in,
    input  logic          beat_in_valid,
    output logic          beat_in_ready,

    output reply_hdr_t    reply_out,
    output logic          reply_out_valid,
    input  logic          reply_out_ready,

    output payload_beat_t beat_out,
    output logic          beat_out_valid,
    input  logic          beat_out_ready
);

    typedef enum logic [1:0] {
        st_idle,
        st_pass,
        st_drop
    } frame_state_t;

    frame_state_t state;
    logic         port_match;
    logic         hdr_accept;
    logic         last_accept;

    assign port_match = (hdr_in.dest_port == `ECHO_PORT);

    // Reply goes back to the sender with the ports swapped
    assign reply_out.ip_dest_ip  = hdr_in.ip_source_ip;
    assign reply_out.source_port = hdr_in.dest_port;
    assign reply_out.dest_port   = hdr_in.source_port;
    assign reply_out.udp_length  = hdr_in.udp_length;

    // Matching headers wait for room in the header queue,
    // others are swallowed right away
    assign reply_out_valid = hdr_in_valid && (state == st_idle) && port_match;
    assign hdr_in_ready    = (state == st_idle) && (!port_match || reply_out_ready);

    assign beat_out       = beat_in;
    assign beat_out_valid = beat_in_valid && (state == st_pass);
    assign beat_in_ready  = ((state == st_pass) && beat_out_ready) || (state == st_drop);

    assign hdr_accept  = hdr_in_valid && hdr_in_ready;
    assign last_accept = beat_in_valid && beat_in_ready && beat_in.tlast;

    // Frame state held until the tlast beat is taken
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (hdr_accept) begin
                        state <= port_match ? st_pass : st_drop;
                    end
                end
                st_pass,
                st_drop: begin
                    if (last_accept) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

// ==== logic/udp_reply_sender.sv ====
// ======================================================================
// Reply header and payload sequencing, LED latch on first beat
// ======================================================================
`timescale 1ns/1ps

module udp_reply_sender
    import udp_echo_pkg::*;
(
    input  logic          clk,
    input  logic          rst,

    input  reply_hdr_t    reply_in,
    input  logic          reply_in_valid,
    output logic          reply_in_ready,

    input  payload_beat_t beat_in,
    input  logic          beat_in_valid,
    output logic          beat_in_ready,

    output reply_hdr_t    reply_out,
    output logic          reply_out_valid,
    input  logic          reply_out_ready,

    output payload_beat_t beat_out,
    output logic          beat_out_valid,
    input  logic          beat_out_ready,

    output logic [7:0]    led
);

    // Low while a header is offered, high while its beats flow
    logic payload_phase;
    logic first_beat;
    logic hdr_accept;
    logic beat_accept;

    assign reply_out       = reply_in;
    assign reply_out_valid = reply_in_valid && !payload_phase;
    assign reply_in_ready  = reply_out_ready && !payload_phase;

    assign beat_out       = beat_in;
    assign beat_out_valid = beat_in_valid && payload_phase;
    assign beat_in_ready  = beat_out_ready && payload_phase;

    assign hdr_accept  = reply_in_valid && reply_in_ready;
    assign beat_accept = beat_in_valid && beat_in_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            payload_phase <= 1'b0;
            first_beat    <= 1'b0;
            led           <= 8'd0;
        end else begin
            if (hdr_accept) begin
                payload_phase <= 1'b1;
                first_beat    <= 1'b1;
            end else if (beat_accept) begin
                first_beat <= 1'b0;
                if (beat_in.tlast) begin
                    payload_phase <= 1'b0;
                end
            end
            // Low byte of the frame's opening beat
            if (beat_accept && first_beat) begin
                led <= beat_in.tdata[7:0];
            end
        end
    end

endmodule

// ==== logic/udp_echo_top.sv ====
// ======================================================================
// Top level of the UDP echo core with port filter, queues and sender
// ======================================================================
`timescale 1ns/1ps
`include "udp_echo_macros.svh"

module udp_echo_top
    import udp_echo_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,

    // Received UDP header
    input  logic                   s_hdr_valid,
    output logic                   s_hdr_ready,
    input  logic [31:0]            s_ip_source_ip,
    input  logic [15:0]            s_source_port,
    input  logic [15:0]            s_dest_port,
    input  logic [15:0]            s_udp_length,

    // Received payload
    input  logic [`DATA_WIDTH-1:0] s_payload_tdata,
    input  logic [`KEEP_WIDTH-1:0] s_payload_tkeep,
    input  logic                   s_payload_tvalid,
    output logic                   s_payload_tready,
    input  logic                   s_payload_tlast,
    input  logic                   s_payload_tuser,

    // Reply header to the transmit stack
    output logic                   m_hdr_valid,
    input  logic                   m_hdr_ready,
    output logic [31:0]            m_ip_dest_ip,
    output logic [15:0]            m_source_port,
    output logic [15:0]            m_dest_port,
    output logic [15:0]            m_udp_length,

    // Reply payload
    output logic [`DATA_WIDTH-1:0] m_payload_tdata,
    output logic [`KEEP_WIDTH-1:0] m_payload_tkeep,
    output logic                   m_payload_tvalid,
    input  logic                   m_payload_tready,
    output logic                   m_payload_tlast,
    output logic                   m_payload_tuser,

    output logic [7:0]             led
);

    udp_hdr_t      s_hdr;
    payload_beat_t s_beat;
    reply_hdr_t    filt_reply;
    logic          filt_reply_valid;
    logic          filt_reply_ready;
    payload_beat_t filt_beat;
    logic          filt_beat_valid;
    logic          filt_beat_ready;
    reply_hdr_t    q_reply;
    logic          q_reply_valid;
    logic          q_reply_ready;
    payload_beat_t q_beat;
    logic          q_beat_valid;
    logic          q_beat_ready;
    reply_hdr_t    m_hdr;
    payload_beat_t m_beat;

    // Pack the flat input ports
    assign s_hdr  = '{s_ip_source_ip, s_source_port, s_dest_port, s_udp_length};
    assign s_beat = '{s_payload_tdata, s_payload_tkeep, s_payload_tlast, s_payload_tuser};

    udp_port_filter filter_inst (
        .clk(clk), .rst(rst),
        .hdr_in(s_hdr), .hdr_in_valid(s_hdr_valid), .hdr_in_ready(s_hdr_ready),
        .beat_in(s_beat), .beat_in_valid(s_payload_tvalid), .beat_in_ready(s_payload_tready),
        .reply_out(filt_reply), .reply_out_valid(filt_reply_valid),
        .reply_out_ready(filt_reply_ready),
        .beat_out(filt_beat), .beat_out_valid(filt_beat_valid),
        .beat_out_ready(filt_beat_ready)
    );

    stream_fifo #(.item_t(reply_hdr_t), .depth(`HDR_FIFO_DEPTH)) hdr_fifo_inst (
        .clk(clk), .rst(rst),
        .in_item(filt_reply), .in_valid(filt_reply_valid), .in_ready(filt_reply_ready),
        .out_item(q_reply), .out_valid(q_reply_valid), .out_ready(q_reply_ready)
    );

    stream_fifo #(.item_t(payload_beat_t), .depth(`PAYLOAD_FIFO_DEPTH)) payload_fifo_inst (
        .clk(clk), .rst(rst),
        .in_item(filt_beat), .in_valid(filt_beat_valid), .in_ready(filt_beat_ready),
        .out_item(q_beat), .out_valid(q_beat_valid), .out_ready(q_beat_ready)
    );

    udp_reply_sender sender_inst (
        .clk(clk), .rst(rst),
        .reply_in(q_reply), .reply_in_valid(q_reply_valid), .reply_in_ready(q_reply_ready),
        .beat_in(q_beat), .beat_in_valid(q_beat_valid), .beat_in_ready(q_beat_ready),
        .reply_out(m_hdr), .reply_out_valid(m_hdr_valid), .reply_out_ready(m_hdr_ready),
        .beat_out(m_beat), .beat_out_valid(m_payload_tvalid),
        .beat_out_ready(m_payload_tready),
        .led(led)
    );

    // Unpack toward the transmit stack
    assign m_ip_dest_ip    = m_hdr.ip_dest_ip;
    assign m_source_port   = m_hdr.source_port;
    assign m_dest_port     = m_hdr.dest_port;
    assign m_udp_length    = m_hdr.udp_length;
    assign m_payload_tdata = m_beat.tdata;
    assign m_payload_tkeep = m_beat.tkeep;
    assign m_payload_tlast = m_beat.tlast;
    assign m_payload_tuser = m_beat.tuser;

endmodule

// ==== test/udp_echo_tb.sv ====
// ======================================================================
// Testbench for the UDP echo core with frames from the vectors file
// ======================================================================
`timescale 1ns/1ps
`include "udp_echo_macros.svh"

module udp_echo_tb;

    localparam int clk_half = 4;

    logic                   clk;
    logic                   rst;
    logic                   s_hdr_valid;
    logic                   s_hdr_ready;
    logic [31:0]            s_ip_source_ip;
    logic [15:0]            s_source_port;
    logic [15:0]            s_dest_port;
    logic [15:0]            s_udp_length;
    logic [`DATA_WIDTH-1:0] s_payload_tdata;
    logic [`KEEP_WIDTH-1:0] s_payload_tkeep;
    logic                   s_payload_tvalid;
    logic                   s_payload_tready;
    logic                   s_payload_tlast;
    logic                   s_payload_tuser;
    logic                   m_hdr_valid;
    logic                   m_hdr_ready;
    logic [31:0]            m_ip_dest_ip;
    logic [15:0]            m_source_port;
    logic [15:0]            m_dest_port;
    logic [15:0]            m_udp_length;
    logic [`DATA_WIDTH-1:0] m_payload_tdata;
    logic [`KEEP_WIDTH-1:0] m_payload_tkeep;
    logic                   m_payload_tvalid;
    logic                   m_payload_tready;
    logic                   m_payload_tlast;
    logic                   m_payload_tuser;
    logic [7:0]             led;

    // One entry per frame line
    int          vec_test[$];
    logic [31:0] vec_ip[$];
    logic [15:0] vec_sport[$];
    logic [15:0] vec_dport[$];
    logic [15:0] vec_len[$];
    int          vec_beats[$];
    logic        vec_tuser[$];
    logic        vec_bp[$];

    // Header as {ip, sport, dport, len} and beat as {tdata, tkeep, tlast, tuser}
    logic [79:0] exp_hdr[$];
    logic [73:0] exp_beat[$];
    logic [31:0] lfsr_state;
    logic        backpressure;
    logic        loaded = 1'b0;
    logic        open_frame;
    logic [7:0]  exp_led;
    int          errors;
    int          checks;
    int          watchdog_cycles;

    udp_echo_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #clk_half clk = ~clk;
    end

    // Taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    function logic random_bit();
        lfsr_state = lfsr_step(lfsr_state);
        return lfsr_state[0];
    endfunction

    function logic [63:0] random_word();
        logic [63:0] w;
        for (int i = 0; i < 64; i++) begin
            w[i] = random_bit();
        end
        return w;
    endfunction

    // Valid bytes of the closing beat
    function automatic logic [7:0] last_keep(input logic [15:0] len);
        int rem;
        rem = len % 8;
        if (rem == 0) begin
            return 8'hff;
        end
        return 8'hff >> (8 - rem);
    endfunction

    task automatic check(input logic [79:0] got, input logic [79:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s got %0h, expected %0h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic report(input string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        errors++;
    endtask

    // Starts and ends on a falling edge; handshakes are sampled 2 ns after it
    task automatic send_frame(input int idx);
        logic        echo;
        logic        last;
        logic [7:0]  keep;
        logic [63:0] data;
        logic [73:0] beat;
        echo = (vec_dport[idx] == `ECHO_PORT);
        backpressure = vec_bp[idx];
        if (echo) begin
            exp_hdr.push_back({vec_ip[idx], vec_dport[idx], vec_sport[idx], vec_len[idx]});
        end
        s_ip_source_ip = vec_ip[idx];
        s_source_port  = vec_sport[idx];
        s_dest_port    = vec_dport[idx];
        s_udp_length   = vec_len[idx];
        s_hdr_valid    = 1'b1;
        #2;
        while (!s_hdr_ready) begin
            @(negedge clk);
            #2;
        end
        @(negedge clk);
        s_hdr_valid = 1'b0;
        for (int b = 0; b < vec_beats[idx]; b++) begin
            data = random_word();
            last = (b == vec_beats[idx] - 1);
            keep = last ? last_keep(vec_len[idx]) : 8'hff;
            beat = {data, keep, last, last & vec_tuser[idx]};
            if (echo) begin
                exp_beat.push_back(beat);
                if (b == 0) begin
                    exp_led = data[7:0];
                end
            end
            {s_payload_tdata, s_payload_tkeep, s_payload_tlast, s_payload_tuser} = beat;
            s_payload_tvalid = 1'b1;
            #2;
            while (!s_payload_tready) begin
                @(negedge clk);
                #2;
            end
            @(negedge clk);
        end
        s_payload_tvalid = 1'b0;
    endtask

    // Output ready drawn on the rising edge and applied on the falling one
    initial begin
        logic hdr_bit;
        logic beat_bit;
        m_hdr_ready      = 1'b1;
        m_payload_tready = 1'b1;
        forever begin
            @(posedge clk);
            hdr_bit  = random_bit();
            beat_bit = random_bit();
            hdr_bit  = !backpressure || hdr_bit;
            beat_bit = !backpressure || beat_bit;
            @(negedge clk);
            m_hdr_ready      = hdr_bit;
            m_payload_tready = beat_bit;
        end
    end

    // Output monitor
    initial begin
        logic [79:0] hdr;
        logic [73:0] beat;
        logic        first_pending;
        logic [7:0]  prev_led;
        open_frame    = 1'b0;
        first_pending = 1'b0;
        prev_led      = 8'd0;
        forever begin
            @(negedge clk);
            #2;
            if (!rst && m_hdr_valid && m_hdr_ready) begin
                if (open_frame) begin
                    report("reply header offered before the previous payload ended");
                end
                // LED still shows the previous echoed frame
                check(80'(led), 80'(prev_led), "led before the next reply");
                if (exp_hdr.size() == 0) begin
                    report("reply header with no echoed frame pending");
                end else begin
                    hdr = exp_hdr.pop_front();
                    check(80'(m_ip_dest_ip), 80'(hdr[79:48]), "destination IP");
                    check(80'(m_source_port), 80'(hdr[47:32]), "source port");
                    check(80'(m_dest_port), 80'(hdr[31:16]), "destination port");
                    check(80'(m_udp_length), 80'(hdr[15:0]), "UDP length");
                end
                open_frame    = 1'b1;
                first_pending = 1'b1;
            end
            if (!rst && m_payload_tvalid && m_payload_tready) begin
                if (!open_frame) begin
                    report("payload beat ahead of its reply header");
                end
                if (exp_beat.size() == 0) begin
                    report("payload beat with no echoed frame pending");
                end else begin
                    beat = exp_beat.pop_front();
                    if (first_pending) begin
                        prev_led = beat[17:10];
                    end
                    check(80'(m_payload_tdata), 80'(beat[73:10]), "tdata");
                    check(80'(m_payload_tkeep), 80'(beat[9:2]), "tkeep");
                    check(80'(m_payload_tlast), 80'(beat[1]), "tlast");
                    check(80'(m_payload_tuser), 80'(beat[0]), "tuser");
                end
                first_pending = 1'b0;
                if (m_payload_tlast) begin
                    open_frame = 1'b0;
                end
            end
        end
    end

    initial begin
        wait (loaded);
        repeat (watchdog_cycles) @(posedge clk);
        $display("TIMEOUT: the DUT stopped making progress after %0d cycles", watchdog_cycles);
        $display("test failed");
        $finish;
    end

    initial begin
        int          fd;
        int          n;
        string       line;
        int          t_id;
        logic [31:0] ip;
        logic [15:0] sp;
        logic [15:0] dp;
        logic [15:0] ln;
        int          nb;
        int          tu;
        int          bp;
        int          total_beats;
        int          idx;
        int          test_no;
        int          frames;
        int          errs_before;
        int          tests_run;
        int          failed_tests;
        rst              = 1'b1;
        s_hdr_valid      = 1'b0;
        s_ip_source_ip   = '0;
        s_source_port    = '0;
        s_dest_port      = '0;
        s_udp_length     = '0;
        s_payload_tdata  = '0;
        s_payload_tkeep  = '0;
        s_payload_tvalid = 1'b0;
        s_payload_tlast  = 1'b0;
        s_payload_tuser  = 1'b0;
        lfsr_state       = 32'h2cb9_73eb;
        backpressure     = 1'b0;
        exp_led          = 8'd0;
        errors           = 0;
        checks           = 0;
        total_beats      = 0;
        tests_run        = 0;
        failed_tests     = 0;
        fd = $fopen("test/udp_echo_vectors.txt", "r");
        if (fd == 0) begin
            $display("ERROR: cannot open test/udp_echo_vectors.txt");
            $display("test failed");
            $finish;
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            n = $sscanf(line, "%d %h %h %h %h %d %d %d", t_id, ip, sp, dp, ln, nb, tu, bp);
            if (n == 8) begin
                vec_test.push_back(t_id);
                vec_ip.push_back(ip);
                vec_sport.push_back(sp);
                vec_dport.push_back(dp);
                vec_len.push_back(ln);
                vec_beats.push_back(nb);
                vec_tuser.push_back(tu[0]);
                vec_bp.push_back(bp[0]);
                total_beats += nb;
            end
        end
        $fclose(fd);
        watchdog_cycles = total_beats * 40 + 2000;
        loaded = 1'b1;

        repeat (2) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        #2;
        errs_before = errors;
        check(80'(m_hdr_valid), '0, "m_hdr_valid after reset");
        check(80'(m_payload_tvalid), '0, "m_payload_tvalid after reset");
        check(80'(led), '0, "led after reset");
        tests_run++;
        if (errors != errs_before) begin
            failed_tests++;
        end
        $display("test 1: reset state, %0d errors", errors - errs_before);
        @(negedge clk);

        idx = 0;
        while (idx < vec_test.size()) begin
            test_no     = vec_test[idx];
            frames      = 0;
            errs_before = errors;
            while (idx < vec_test.size() && vec_test[idx] == test_no) begin
                send_frame(idx);
                idx++;
                frames++;
            end
            // Let the echoes drain, then give stray output time to appear
            while (exp_hdr.size() != 0 || exp_beat.size() != 0) begin
                @(negedge clk);
            end
            repeat (20) @(negedge clk);
            check(80'(led), 80'(exp_led), "led byte");
            tests_run++;
            if (errors != errs_before) begin
                failed_tests++;
            end
            $display("test %0d: %0d frames, %0d errors", test_no, frames, errors - errs_before);
        end

        $display("summary: %0d tests, %0d with errors, %0d checks, %0d errors",
                 tests_run, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+logic
logic/udp_echo_pkg.sv
logic/stream_fifo.sv
logic/udp_port_filter.sv
logic/udp_reply_sender.sv
logic/udp_echo_top.sv
test/udp_echo_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the UDP echo testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f list.f --top-module udp_echo_tb -o udp_echo_sim

out=$(./obj_dir/udp_echo_sim)
echo "$out"

if echo "$out" | grep -qx "test passed"; then
    exit 0
fi
exit 1

// ==== test/udp_echo_vectors.txt ====
# test src_ip src_port dst_port udp_len beats tuser backpressure
# ip, ports and length in hex; beats cover the payload after the 8-byte UDP header
# test 2: echo, full and partial last beat
2 c0a80105 c350 04d2 0028 4 0 0
2 c0a80105 c351 04d2 001d 3 1 0
# test 3: other ports dropped, then an echo
3 0a000002 1f40 0035 0030 5 0 0
3 0a000003 1f41 1f90 0011 2 1 0
3 0a000004 1f42 04d2 0024 4 0 0
# test 4: led follows the last echoed frame
4 ac100001 2710 04d2 0010 1 0 0
4 ac100002 2711 04d3 0019 3 0 0
4 ac100003 2712 04d2 0022 4 0 0
# test 5: back-to-back frames under random output back-pressure
5 c0a80a01 e000 04d2 0040 7 0 1
5 c0a80a02 e001 04d2 0009 1 1 1
5 c0a80a03 e002 04d2 0017 2 0 1
5 c0a80a04 e003 0050 0020 3 0 1
5 c0a80a05 e004 04d2 0012 2 0 1
5 c0a80a06 e005 04d2 0058 10 0 1
5 c0a80a07 e006 04d2 001b 3 1 1
5 c0a80a08 e007 04d2 000e 1 0 1
5 c0a80a09 e008 04d2 0030 5 0 1
5 c0a80a0a e009 04d2 0015 2 0 1
